/* verilog/axi_read_params.svh */
`ifndef AXI_READ_PARAMS_SVH
`define AXI_READ_PARAMS_SVH

// Bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4
`define OFFSET_W   2
`define AXI_ID_W   4
`define AXI_LEN_W  8

// Request byte count
`define LEN_W 12

// Burst limits
`define MAX_BEATS 16
`define BOUNDARY  4096   // Bytes per page, bursts stay inside one

// Fixed AR field values
`define AXI_SIZE_VAL   3'b010   // 4 bytes per beat
`define AXI_BURST_INCR 2'b01
`define AXI_CACHE_VAL  4'h2
`define AXI_PROT_VAL   3'b010

`endif

/* verilog/axi_read_pkg.sv */
`include "axi_read_params.svh"

package axi_read_pkg;

  // Byte-oriented read request
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`LEN_W-1:0]      len;   // Bytes
  } rd_req_t;

  // AR channel payload, handshake bits travel separately
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_LEN_W-1:0]  len;
    logic [2:0]             size;
    logic [1:0]             burst;
    logic                   lock;
    logic [3:0]             cache;
    logic [2:0]             prot;
    logic [3:0]             qos;
  } ar_chan_t;

  // R channel payload
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } r_chan_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic                   last;
  } out_word_t;

  // One burst as planned by the controller
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_LEN_W-1:0]  len;
    logic                   last;   // Final burst of the transfer
  } burst_plan_t;

endpackage

/* verilog/transfer_controller.sv */
`timescale 1ns/1ps
`include "axi_read_params.svh"

module transfer_controller (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      transfer_start,
  input  axi_read_pkg::rd_req_t     req,
  input  logic                      burst_start,
  output axi_read_pkg::burst_plan_t plan
);
  import axi_read_pkg::*;

  localparam int CNT_W  = `LEN_W + 1;
  localparam int ADDR_W = `AXI_ADDR_W;
  localparam int PAGE_W = $clog2(`BOUNDARY);

  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  remaining;   // Beats still to request
  logic [CNT_W-1:0]  start_beats;
  logic [CNT_W-1:0]  edge_bytes;
  logic [CNT_W-1:0]  edge_beats;
  logic [CNT_W-1:0]  cap_beats;
  logic [CNT_W-1:0]  burst_beats;
  logic [CNT_W-1:0]  burst_len;

  // Offset plus byte count, rounded up to whole beats
  assign start_beats = (CNT_W'(req.addr[`OFFSET_W-1:0]) + CNT_W'(req.len)
                        + CNT_W'(`AXI_STRB_W - 1)) >> `OFFSET_W;

  // Room left in the current 4 KB page
  assign edge_bytes = CNT_W'(`BOUNDARY) - CNT_W'(addr_q[PAGE_W-1:0]);
  assign edge_beats = edge_bytes >> `OFFSET_W;

  assign cap_beats   = (remaining < CNT_W'(`MAX_BEATS)) ? remaining : CNT_W'(`MAX_BEATS);
  assign burst_beats = (edge_beats < cap_beats) ? edge_beats : cap_beats;
  assign burst_len   = burst_beats - 1'b1;

  always_comb begin
    plan.addr = addr_q;
    plan.len  = burst_len[`AXI_LEN_W-1:0];
    plan.last = (burst_beats == remaining);
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      addr_q    <= '0;
      remaining <= '0;
    end else if (transfer_start) begin
      addr_q    <= {req.addr[ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};  // Beat aligned
      remaining <= start_beats;
    end else if (burst_start) begin
      addr_q    <= addr_q + (ADDR_W'(burst_beats) << `OFFSET_W);
      remaining <= remaining - burst_beats;
    end
  end

endmodule

/* verilog/burst_align.sv */
`timescale 1ns/1ps
`include "axi_read_params.svh"

module burst_align (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  logic [`OFFSET_W-1:0]    offset,
  input  axi_read_pkg::rd_req_t   req,
  input  logic                    beat_valid,
  input  axi_read_pkg::r_chan_t   beat,
  output logic                    out_valid,
  output axi_read_pkg::out_word_t out,
  output logic                    empty
);
  import axi_read_pkg::*;

  localparam int CNT_W  = `LEN_W + 1;
  localparam int DATA_W = `AXI_DATA_W;
  localparam int SH_W   = $clog2(DATA_W) + 1;

  logic [`OFFSET_W-1:0] off_q;
  logic [CNT_W-1:0]     words_left;
  logic [CNT_W-1:0]     beats_left;
  logic [CNT_W-1:0]     start_words;
  logic [CNT_W-1:0]     start_beats;
  logic [CNT_W-1:0]     words_next;
  logic [DATA_W-1:0]    prev;   // Last beat taken
  logic                 have_prev;
  logic                 flush_pend;
  logic [SH_W-1:0]      lo_shift;
  logic [SH_W-1:0]      hi_shift;
  logic                 emit_join;
  logic                 emit_flush;
  logic                 emit;
  logic [DATA_W-1:0]    word_d;

  assign start_words = (CNT_W'(req.len) + CNT_W'(`AXI_STRB_W - 1)) >> `OFFSET_W;
  assign start_beats = (CNT_W'(offset) + CNT_W'(req.len)
                        + CNT_W'(`AXI_STRB_W - 1)) >> `OFFSET_W;

  assign lo_shift = SH_W'(off_q) << 3;
  assign hi_shift = SH_W'(DATA_W) - lo_shift;

  always_comb begin
    emit_join  = 1'b0;
    emit_flush = 1'b0;
    word_d     = prev >> lo_shift;   // Flush word, upper bytes of held beat
    if (flush_pend) begin
      emit_flush = 1'b1;
    end else if (beat_valid && words_left != '0) begin
      if (off_q == '0) begin
        emit_join = 1'b1;
        word_d    = beat.data;
      end else if (have_prev) begin
        emit_join = 1'b1;
        word_d    = (prev >> lo_shift) | (beat.data << hi_shift);
      end
    end
  end

  assign emit       = emit_join | emit_flush;
  assign words_next = emit ? words_left - 1'b1 : words_left;
  assign empty      = (words_left == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      off_q      <= '0;
      words_left <= '0;
      beats_left <= '0;
      have_prev  <= 1'b0;
      flush_pend <= 1'b0;
      out_valid  <= 1'b0;
    end else if (start) begin
      off_q      <= offset;
      words_left <= start_words;
      beats_left <= start_beats;
      have_prev  <= 1'b0;
      flush_pend <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      out_valid  <= emit;
      words_left <= words_next;
      if (emit_flush) begin
        flush_pend <= 1'b0;
      end
      if (beat_valid) begin
        have_prev  <= 1'b1;
        beats_left <= beats_left - 1'b1;
        // Beats ran out one word short
        if (beats_left == CNT_W'(1) && words_next != '0) begin
          flush_pend <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid) begin
      prev <= beat.data;
    end
    if (emit) begin
      out.data <= word_d;
      out.last <= (words_left == CNT_W'(1));
    end
  end

endmodule

/* verilog/simple_axi_read.sv */
`timescale 1ns/1ps
`include "axi_read_params.svh"

module simple_axi_read (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_valid,
  input  axi_read_pkg::rd_req_t   req,
  output logic                    busy,
  output logic                    ar_valid,
  output axi_read_pkg::ar_chan_t  ar,
  input  logic                    ar_ready,
  input  logic                    r_valid,
  input  axi_read_pkg::r_chan_t   r,
  output logic                    r_ready,
  output logic                    out_valid,
  output axi_read_pkg::out_word_t out
);
  import axi_read_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_PREP,
    S_ADDR,
    S_DATA
  } state_t;

  state_t                state;
  burst_plan_t           plan;
  logic [`AXI_LEN_W-1:0] len_q;
  logic                  last_q;   // Current burst ends the transfer
  logic                  empty;
  logic                  accept;
  logic                  burst_start;
  logic                  beat_fire;

  // Held through the flush word and the last output strobe
  assign busy        = (state != S_IDLE) || !empty || out_valid;
  assign accept      = req_valid && !busy;
  assign burst_start = (state == S_ADDR) && ar_valid && ar_ready;
  assign r_ready     = (state == S_DATA);
  assign beat_fire   = r_valid && r_ready;

  transfer_controller read_controller (
    .clk            (clk),
    .rst            (rst),
    .transfer_start (accept),
    .req            (req),
    .burst_start    (burst_start),
    .plan           (plan)
  );

  burst_align aligner (
    .clk        (clk),
    .rst        (rst),
    .start      (accept),
    .offset     (req.addr[`OFFSET_W-1:0]),
    .req        (req),
    .beat_valid (beat_fire),
    .beat       (r),
    .out_valid  (out_valid),
    .out        (out),
    .empty      (empty)
  );

  always_comb begin
    ar       = '0;   // ID, lock and QoS stay zero
    ar.addr  = plan.addr;
    ar.len   = len_q;
    ar.size  = `AXI_SIZE_VAL;
    ar.burst = `AXI_BURST_INCR;
    ar.cache = `AXI_CACHE_VAL;
    ar.prot  = `AXI_PROT_VAL;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= S_IDLE;
      ar_valid <= 1'b0;
      len_q    <= '0;
      last_q   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            state <= S_PREP;
          end
        end
        S_PREP: begin
          ar_valid <= 1'b1;
          len_q    <= plan.len;
          last_q   <= plan.last;
          state    <= S_ADDR;
        end
        S_ADDR: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= S_DATA;
          end
        end
        S_DATA: begin
          if (beat_fire && r.last) begin
            state <= last_q ? S_IDLE : S_PREP;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* verilog/axi_read_top.sv */
`timescale 1ns/1ps

module axi_read_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_valid,
  input  axi_read_pkg::rd_req_t   req,
  output logic                    busy,
  output logic                    ar_valid,
  output axi_read_pkg::ar_chan_t  ar,
  input  logic                    ar_ready,
  input  logic                    r_valid,
  input  axi_read_pkg::r_chan_t   r,
  output logic                    r_ready,
  output logic                    out_valid,
  output axi_read_pkg::out_word_t out
);

  // Single read bridge, AXI master side faces the memory
  simple_axi_read bridge0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .busy      (busy),
    .ar_valid  (ar_valid),
    .ar        (ar),
    .ar_ready  (ar_ready),
    .r_valid   (r_valid),
    .r         (r),
    .r_ready   (r_ready),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

/* tb/axi_read_props.sv */
`timescale 1ns/1ps
`include "axi_read_params.svh"

module axi_read_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   ar_valid,
  input logic                   ar_ready,
  input axi_read_pkg::ar_chan_t ar,
  input logic                   r_ready,
  input logic                   busy,
  input logic                   out_valid
);
  import axi_read_pkg::*;

  localparam int PAGE_W = $clog2(`BOUNDARY);

  logic [PAGE_W+1:0] burst_end;   // Page offset just past the burst

  assign burst_end = (PAGE_W+2)'(ar.addr[PAGE_W-1:0])
                     + (((PAGE_W+2)'(ar.len) + 1'b1) << `OFFSET_W);

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else $error("AR request dropped or changed before ar_ready");

  a_ar_len: assert property (@(posedge clk) disable iff (rst)
    ar_valid |-> ar.len <= 8'(`MAX_BEATS - 1))
    else $error("Burst longer than 16 beats");

  a_ar_page: assert property (@(posedge clk) disable iff (rst)
    ar_valid |-> burst_end <= (PAGE_W+2)'(`BOUNDARY))
    else $error("Burst crosses a 4 KB boundary");

  a_out_busy: assert property (@(posedge clk) disable iff (rst) !busy |=> !out_valid)
    else $error("Output word in the cycle after the bridge was idle");

  a_r_ready: assert property (@(posedge clk) disable iff (rst) ar_valid |-> !r_ready)
    else $error("r_ready high during address phase");

endmodule

/* tb/axi_read_tb.sv */
`timescale 1ns/1ps

module axi_read_tb;
  import axi_read_pkg::*;

  localparam int AR_LIMIT   = 200;
  localparam int IDLE_LIMIT = 40000;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        req_valid = 1'b0;
  rd_req_t     req = '0;
  logic        busy;
  logic        ar_valid;
  ar_chan_t    ar;
  logic        ar_ready = 1'b0;
  logic        r_valid = 1'b0;
  r_chan_t     r = '0;
  logic        r_ready;
  logic        out_valid;
  out_word_t   out;

  integer      seed = 32'h7dd;
  bit          stall_en;
  bit          timed_out;
  int          errors;
  logic [31:0] exp_addr;
  int          exp_len;
  int          exp_words;
  int          words_seen;
  int          last_count;
  int          burst_count;
  int          beat_sum;
  logic [31:0] next_addr;   // Where the next burst should start
  logic [31:0] m_addr;
  int          m_left;
  bit          m_active;

  axi_read_top dut0 (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req(req), .busy(busy),
    .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready), .r_valid(r_valid), .r(r),
    .r_ready(r_ready), .out_valid(out_valid), .out(out)
  );

  bind axi_read_top axi_read_props props0 (
    .clk(clk), .rst(rst), .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
    .r_ready(r_ready), .busy(busy), .out_valid(out_valid)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0t ns: %s = %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  // Memory content rule
  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    logic [31:0] v;
    v = a * 32'd7 + 32'd3;
    return v[7:0];
  endfunction

  function automatic logic [31:0] beat_data(input logic [31:0] a);
    logic [31:0] d;
    for (int j = 0; j < 4; j++) begin
      d[8*j +: 8] = mem_byte(a + 32'(j));
    end
    return d;
  endfunction

  function automatic logic pick_go();
    if (!stall_en) return 1'b1;
    return ($random(seed) & 3) != 0;   // Roughly one gap in four
  endfunction

  task automatic log_burst();
    int beats;
    beats = int'(ar.len) + 1;
    check_value("ar.addr", ar.addr, next_addr);
    check_value("ar.id", 32'(ar.id), 32'd0);
    check_value("ar.size", 32'(ar.size), 32'd2);
    check_value("ar.burst", 32'(ar.burst), 32'd1);
    check_value("ar.lock", 32'(ar.lock), 32'd0);
    check_value("ar.cache", 32'(ar.cache), 32'h2);
    check_value("ar.prot", 32'(ar.prot), 32'd2);
    check_value("ar.qos", 32'(ar.qos), 32'd0);
    check_value("ar.len above 15", 32'(ar.len > 8'd15), 32'd0);
    check_value("ar crosses 4 KB", 32'((32'(ar.addr[11:0]) + beats * 4) > 4096), 32'd0);
    next_addr   = ar.addr + 32'(beats * 4);
    burst_count = burst_count + 1;
    beat_sum    = beat_sum + beats;
  endtask

  // AXI slave model serving one burst at a time
  always @(posedge clk) begin
    if (rst) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      r        <= '0;
      m_active = 1'b0;
      m_left   = 0;
    end else begin
      if (r_valid && r_ready) begin
        m_addr = m_addr + 32'd4;
        m_left = m_left - 1;
        if (m_left == 0) m_active = 1'b0;
      end
      if (ar_valid && ar_ready) begin
        log_burst();
        m_active = 1'b1;
        m_addr   = ar.addr;
        m_left   = int'(ar.len) + 1;
      end
      ar_ready <= !m_active && pick_go();
      if (!m_active) begin
        r_valid <= 1'b0;
      end else if (!r_valid || r_ready) begin
        r_valid <= pick_go();
        r.id    <= '0;
        r.data  <= beat_data(m_addr);
        r.resp  <= 2'b00;
        r.last  <= (m_left == 1);
      end
    end
  end

  always @(posedge clk) begin
    logic [31:0] mask;
    logic [31:0] expect_w;
    if (!rst && out_valid) begin
      if (words_seen >= exp_words) begin
        errors++;
        $display("Extra output word at %0t ns beyond the requested count", $time);
      end else begin
        mask     = '0;
        expect_w = '0;
        for (int j = 0; j < 4; j++) begin
          if (words_seen * 4 + j < exp_len) begin   // Bytes past the count are don't care
            mask[8*j +: 8]     = 8'hff;
            expect_w[8*j +: 8] = mem_byte(exp_addr + 32'(words_seen * 4 + j));
          end
        end
        check_value("out.data", out.data & mask, expect_w);
        check_value("out.last", 32'(out.last), 32'(words_seen == exp_words - 1));
      end
      words_seen++;
      if (out.last) last_count++;
    end
  end

  task automatic run_request(input logic [31:0] start_addr, input int byte_cnt,
                             input int stall, input int words, input int bursts);
    int lat;
    int waited;
    int total_beats;
    total_beats = (int'(start_addr[1:0]) + byte_cnt + 3) / 4;
    stall_en    = (stall != 0);
    exp_addr    = start_addr;
    exp_len     = byte_cnt;
    exp_words   = words;
    words_seen  = 0;
    last_count  = 0;
    burst_count = 0;
    beat_sum    = 0;
    next_addr   = {start_addr[31:2], 2'b00};
    check_value("stimulus word count", 32'(words), 32'((byte_cnt + 3) / 4));
    @(posedge clk);
    req_valid <= 1'b1;
    req.addr  <= start_addr;
    req.len   <= byte_cnt[11:0];
    @(posedge clk);
    req_valid <= 1'b0;
    lat = 1;
    while (!ar_valid && lat < AR_LIMIT) begin
      @(posedge clk);
      lat++;
    end
    if (!ar_valid) begin
      $display("Timeout at %0t ns: ar_valid never rose after the request", $time);
      errors++;
      timed_out = 1'b1;
    end else begin
      check_value("ar_valid latency", 32'(lat), 32'd3);   // Strobe edge plus two cycles
      check_value("busy", 32'(busy), 32'd1);
      req_valid <= 1'b1;   // Must be ignored
      req.addr  <= 32'h0000_f000;
      req.len   <= 12'd8;
      @(posedge clk);
      req_valid <= 1'b0;
      waited = 0;
      while (busy && waited < IDLE_LIMIT) begin
        @(posedge clk);
        waited++;
      end
      if (busy) begin
        $display("Timeout at %0t ns: bridge stayed busy for request at %h", $time, start_addr);
        errors++;
        timed_out = 1'b1;
      end else begin
        check_value("output word count", 32'(words_seen), 32'(words));
        check_value("out.last pulses", 32'(last_count), 32'd1);
        check_value("burst count", 32'(burst_count), 32'(bursts));
        check_value("beat total", 32'(beat_sum), 32'(total_beats));
      end
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          n;
    string       line;
    logic [31:0] f_addr;
    int          f_len;
    int          f_stall;
    int          f_words;
    int          f_bursts;
    errors    = 0;
    timed_out = 1'b0;
    stall_en  = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value("busy after reset", 32'(busy), 32'd0);
    check_value("ar_valid after reset", 32'(ar_valid), 32'd0);
    check_value("r_ready after reset", 32'(r_ready), 32'd0);
    check_value("out_valid after reset", 32'(out_valid), 32'd0);
    fd = $fopen("tb/axi_read_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/axi_read_stimulus.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %d %d %d %d", f_addr, f_len, f_stall, f_words, f_bursts);
          if (n == 5) run_request(f_addr, f_len, f_stall, f_words, f_bursts);
        end
      end
      $fclose(fd);
    end
    $display("Run complete with %0d errors", errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb/axi_read_stimulus.txt */
# address(hex) byte_count stall expected_words expected_bursts
# stall 1 turns on random ar_ready and r_valid gaps
00000100 16 0 4 1
00000201 12 0 3 1
00000302 7 0 2 1
00000403 1 0 1 1
00000501 3 0 1 1
00001000 200 0 50 4
00001ff8 40 0 10 2
00002ff9 30 0 8 2
00003003 200 1 50 4
00000ffc 64 1 16 2
00005002 100 1 25 2
00006ff0 5 1 2 1
00007ffe 18 1 5 2
00008000 64 1 16 1
00009001 255 1 64 4
0000bffd 9 1 3 2
00000c02 2 1 1 1
0000a0c0 4095 0 1024 64

/* compile.f */
+incdir+verilog
verilog/axi_read_pkg.sv
verilog/transfer_controller.sv
verilog/burst_align.sv
verilog/simple_axi_read.sv
verilog/axi_read_top.sv
tb/axi_read_props.sv
tb/axi_read_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only -Wall --timing
TOP      = axi_read_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
